//--- hdl/ahbl_pkg.sv
// AHB-Lite master shared definitions
package ahbl_pkg;

  // ========================================
  // AHB-Lite encodings
  // ========================================
  localparam logic [1:0] htrans_idle   = 2'b00;
  localparam logic [1:0] htrans_nonseq = 2'b10;

  localparam logic [2:0] hburst_single = 3'b000;

  // ========================================
  // Field widths
  // ========================================
  localparam int prot_w  = 4;
  localparam int size_w  = 2;
  // HSIZE is the requester size zero-extended
  localparam int hsize_w = 3;

  // Port vector bit positions
  localparam int port_dbus = 0;
  localparam int port_ibus = 1;

  // ========================================
  // Master state encoding
  // ========================================
  // Error states share the upper bits
  typedef enum logic [2:0] {
    st_idle = 3'b000,
    st_wfd  = 3'b001,
    st_wfg  = 3'b010,
    st_err1 = 3'b110,
    st_err2 = 3'b111
  } master_state_t;

endpackage

//--- hdl/ahbl_req_arb.sv
// Request arbiter and command mux
`timescale 1ns/1ns

module ahbl_req_arb #(
  parameter int addr_width = 32,
  parameter int data_width = 32
) (
  input  logic                          dbus_req,
  input  logic                          ibus_req,
  input  logic [addr_width-1:0]         dbus_addr,
  input  logic [addr_width-1:0]         ibus_addr,
  input  logic [ahbl_pkg::prot_w-1:0]   dbus_prot,
  input  logic [ahbl_pkg::prot_w-1:0]   ibus_prot,
  input  logic [ahbl_pkg::size_w-1:0]   dbus_size,
  input  logic [ahbl_pkg::size_w-1:0]   ibus_size,
  input  logic                          dbus_write,
  input  logic [data_width-1:0]         dbus_wdata,
  input  logic                          dbus_acc_deny,
  input  logic                          ibus_acc_deny,
  input  logic                          buf_vld,
  input  logic                          fsm_ready,
  output logic                          dbus_grnt,
  output logic                          ibus_grnt,
  output logic                          grant,
  output logic [1:0]                    cmd_sel,
  output logic [addr_width-1:0]         cmd_addr,
  output logic [ahbl_pkg::prot_w-1:0]   cmd_prot,
  output logic [ahbl_pkg::size_w-1:0]   cmd_size,
  output logic                          cmd_write,
  output logic [data_width-1:0]         cmd_wdata,
  output logic                          cmd_deny
);
  import ahbl_pkg::*;

  logic dbus_sel;
  logic ibus_sel;
  logic slot_free;

  // Fixed priority, dbus first
  assign dbus_sel = dbus_req;
  assign ibus_sel = ibus_req & ~dbus_req;

  // Only one request in flight
  assign slot_free = ~buf_vld & fsm_ready;

  assign grant     = (dbus_req | ibus_req) & slot_free;
  assign dbus_grnt = dbus_sel & slot_free;
  assign ibus_grnt = ibus_sel & slot_free;

  always_comb
  begin
    cmd_sel            = '0;
    cmd_sel[port_dbus] = dbus_sel;
    cmd_sel[port_ibus] = ibus_sel;
  end

  // Winner's fields, ibus never writes
  assign cmd_addr  = dbus_sel ? dbus_addr     : ibus_addr;
  assign cmd_prot  = dbus_sel ? dbus_prot     : ibus_prot;
  assign cmd_size  = dbus_sel ? dbus_size     : ibus_size;
  assign cmd_deny  = dbus_sel ? dbus_acc_deny : ibus_acc_deny;
  assign cmd_write = dbus_sel & dbus_write;
  assign cmd_wdata = dbus_sel ? dbus_wdata : '0;

endmodule

//--- hdl/ahbl_req_buf.sv
// One-entry request buffer
`timescale 1ns/1ns

module ahbl_req_buf #(
  parameter int addr_width = 32,
  parameter int data_width = 32
) (
  input  logic                          ahbl_gated_clk,
  input  logic                          cpurst_b,
  input  logic                          grant,
  input  logic [1:0]                    cmd_sel,
  input  logic [addr_width-1:0]         cmd_addr,
  input  logic [ahbl_pkg::prot_w-1:0]   cmd_prot,
  input  logic [ahbl_pkg::size_w-1:0]   cmd_size,
  input  logic                          cmd_write,
  input  logic [data_width-1:0]         cmd_wdata,
  input  logic                          cmd_deny,
  input  logic                          pop,
  input  logic                          trans_cmplt,
  input  logic                          acc_err,
  output logic                          buf_vld,
  output logic                          buf_deny,
  output logic [addr_width-1:0]         haddr,
  output logic [ahbl_pkg::prot_w-1:0]   hprot,
  output logic [ahbl_pkg::hsize_w-1:0]  hsize,
  output logic                          hwrite,
  output logic [data_width-1:0]         hwdata,
  output logic                          dbus_trans_cmplt,
  output logic                          ibus_trans_cmplt,
  output logic                          dbus_acc_err,
  output logic                          ibus_acc_err
);
  import ahbl_pkg::*;

  logic [1:0]          sel_q;
  logic [size_w-1:0]   size_q;

  // ========================================
  // Control state
  // ========================================
  always_ff @(posedge ahbl_gated_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      buf_vld  <= 1'b0;
      buf_deny <= 1'b0;
      sel_q    <= '0;
    end
    else if (grant)
    begin
      buf_vld  <= 1'b1;
      buf_deny <= cmd_deny;
      sel_q    <= cmd_sel;
    end
    else if (pop)
    begin
      buf_vld  <= 1'b0;
    end
  end

  // Command payload, write data captured with the command
  always_ff @(posedge ahbl_gated_clk)
  begin
    if (grant)
    begin
      haddr  <= cmd_addr;
      hprot  <= cmd_prot;
      size_q <= cmd_size;
      hwrite <= cmd_write;
      hwdata <= cmd_wdata;
    end
  end

  assign hsize = {{(hsize_w - size_w){1'b0}}, size_q};

  // ========================================
  // Completion routing
  // ========================================
  assign dbus_trans_cmplt = trans_cmplt & sel_q[port_dbus];
  assign ibus_trans_cmplt = trans_cmplt & sel_q[port_ibus];
  assign dbus_acc_err     = acc_err & sel_q[port_dbus];
  assign ibus_acc_err     = acc_err & sel_q[port_ibus];

  // Arbiter must never load over a live entry
  a_no_grant_when_full: assert property (
    @(posedge ahbl_gated_clk) disable iff (!cpurst_b)
    grant |-> !buf_vld);

endmodule

//--- hdl/ahbl_master_fsm.sv
// AHB-Lite transfer state machine
`timescale 1ns/1ns

module ahbl_master_fsm (
  input  logic       ahbl_gated_clk,
  input  logic       cpurst_b,
  input  logic       buf_vld,
  input  logic       buf_deny,
  input  logic       hready,
  input  logic       hresp,
  output logic [1:0] htrans,
  output logic       fsm_ready,
  output logic       pop,
  output logic       trans_cmplt,
  output logic       acc_err
);
  import ahbl_pkg::*;

  master_state_t state_q;
  master_state_t state_nxt;
  logic          good_done;
  logic          deny_done;

  // ========================================
  // State register
  // ========================================
  always_ff @(posedge ahbl_gated_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      state_q <= st_idle;
    else
      state_q <= state_nxt;
  end

  always_comb
  begin
    state_nxt = state_q;
    case (state_q)
      st_idle:
      begin
        // Denied requests skip the address phase
        if (buf_vld)
          state_nxt = (hready | buf_deny) ? st_wfd : st_wfg;
      end
      st_wfg:
      begin
        if (hready)
          state_nxt = st_wfd;
      end
      st_wfd:
      begin
        if (hresp)
          state_nxt = st_err1;
        else if (hready | buf_deny)
          state_nxt = st_idle;
      end
      st_err1:
      begin
        // Second ERROR cycle
        if (hready | !hresp)
          state_nxt = st_err2;
      end
      st_err2:
        state_nxt = st_idle;
      default:
        state_nxt = st_idle;
    endcase
  end

  // ========================================
  // Outputs
  // ========================================
  always_comb
  begin
    if ((state_q == st_wfg) || (state_q == st_idle && buf_vld && !buf_deny))
      htrans = htrans_nonseq;
    else
      htrans = htrans_idle;
  end

  assign fsm_ready = (state_q == st_idle) | ((state_q == st_wfd) & hready);

  assign good_done = (state_q == st_wfd) & hready & ~hresp;
  assign deny_done = (state_q == st_wfd) & buf_vld & buf_deny;

  assign trans_cmplt = good_done | deny_done | (state_q == st_err2);
  assign pop         = trans_cmplt;
  assign acc_err     = (state_q == st_err2);

  // Held NONSEQ keeps its buffered request through wait states
  a_wfg_req_held: assert property (
    @(posedge ahbl_gated_clk) disable iff (!cpurst_b)
    state_q == st_wfg |-> buf_vld && !buf_deny);

endmodule

//--- hdl/ahbl_master_top.sv
// AHB-Lite master interface top
`timescale 1ns/1ns

module ahbl_master_top #(
  parameter int addr_width = 32,
  parameter int data_width = 32
) (
  input  logic                          ahbl_gated_clk,
  input  logic                          cpurst_b,
  // dbus requester
  input  logic                          dbus_req,
  input  logic [addr_width-1:0]         dbus_addr,
  input  logic [ahbl_pkg::prot_w-1:0]   dbus_prot,
  input  logic [ahbl_pkg::size_w-1:0]   dbus_size,
  input  logic                          dbus_acc_deny,
  input  logic                          dbus_write,
  input  logic [data_width-1:0]         dbus_wdata,
  output logic                          dbus_grnt,
  output logic                          dbus_trans_cmplt,
  output logic                          dbus_acc_err,
  output logic [data_width-1:0]         dbus_rdata,
  // ibus requester
  input  logic                          ibus_req,
  input  logic [addr_width-1:0]         ibus_addr,
  input  logic [ahbl_pkg::prot_w-1:0]   ibus_prot,
  input  logic [ahbl_pkg::size_w-1:0]   ibus_size,
  input  logic                          ibus_acc_deny,
  output logic                          ibus_grnt,
  output logic                          ibus_trans_cmplt,
  output logic                          ibus_acc_err,
  output logic [data_width-1:0]         ibus_rdata,
  // AHB-Lite bus
  output logic [addr_width-1:0]         haddr,
  output logic [1:0]                    htrans,
  output logic                          hwrite,
  output logic [ahbl_pkg::hsize_w-1:0]  hsize,
  output logic [ahbl_pkg::prot_w-1:0]   hprot,
  output logic [2:0]                    hburst,
  output logic [data_width-1:0]         hwdata,
  input  logic [data_width-1:0]         hrdata,
  input  logic                          hready,
  input  logic                          hresp
);
  import ahbl_pkg::*;

  logic                  grant;
  logic [1:0]            cmd_sel;
  logic [addr_width-1:0] cmd_addr;
  logic [prot_w-1:0]     cmd_prot;
  logic [size_w-1:0]     cmd_size;
  logic                  cmd_write;
  logic [data_width-1:0] cmd_wdata;
  logic                  cmd_deny;
  logic                  buf_vld;
  logic                  buf_deny;
  logic                  fsm_ready;
  logic                  pop;
  logic                  trans_cmplt;
  logic                  acc_err;

  // Single transfers only
  assign hburst     = hburst_single;
  // Read data goes to both ports, completion qualifies it
  assign dbus_rdata = hrdata;
  assign ibus_rdata = hrdata;

  ahbl_req_arb #(
    .addr_width (addr_width),
    .data_width (data_width)
  ) u_arb (
    .dbus_req      (dbus_req),
    .ibus_req      (ibus_req),
    .dbus_addr     (dbus_addr),
    .ibus_addr     (ibus_addr),
    .dbus_prot     (dbus_prot),
    .ibus_prot     (ibus_prot),
    .dbus_size     (dbus_size),
    .ibus_size     (ibus_size),
    .dbus_write    (dbus_write),
    .dbus_wdata    (dbus_wdata),
    .dbus_acc_deny (dbus_acc_deny),
    .ibus_acc_deny (ibus_acc_deny),
    .buf_vld       (buf_vld),
    .fsm_ready     (fsm_ready),
    .dbus_grnt     (dbus_grnt),
    .ibus_grnt     (ibus_grnt),
    .grant         (grant),
    .cmd_sel       (cmd_sel),
    .cmd_addr      (cmd_addr),
    .cmd_prot      (cmd_prot),
    .cmd_size      (cmd_size),
    .cmd_write     (cmd_write),
    .cmd_wdata     (cmd_wdata),
    .cmd_deny      (cmd_deny)
  );

  ahbl_req_buf #(
    .addr_width (addr_width),
    .data_width (data_width)
  ) u_buf (
    .ahbl_gated_clk   (ahbl_gated_clk),
    .cpurst_b         (cpurst_b),
    .grant            (grant),
    .cmd_sel          (cmd_sel),
    .cmd_addr         (cmd_addr),
    .cmd_prot         (cmd_prot),
    .cmd_size         (cmd_size),
    .cmd_write        (cmd_write),
    .cmd_wdata        (cmd_wdata),
    .cmd_deny         (cmd_deny),
    .pop              (pop),
    .trans_cmplt      (trans_cmplt),
    .acc_err          (acc_err),
    .buf_vld          (buf_vld),
    .buf_deny         (buf_deny),
    .haddr            (haddr),
    .hprot            (hprot),
    .hsize            (hsize),
    .hwrite           (hwrite),
    .hwdata           (hwdata),
    .dbus_trans_cmplt (dbus_trans_cmplt),
    .ibus_trans_cmplt (ibus_trans_cmplt),
    .dbus_acc_err     (dbus_acc_err),
    .ibus_acc_err     (ibus_acc_err)
  );

  ahbl_master_fsm u_fsm (
    .ahbl_gated_clk (ahbl_gated_clk),
    .cpurst_b       (cpurst_b),
    .buf_vld        (buf_vld),
    .buf_deny       (buf_deny),
    .hready         (hready),
    .hresp          (hresp),
    .htrans         (htrans),
    .fsm_ready      (fsm_ready),
    .pop            (pop),
    .trans_cmplt    (trans_cmplt),
    .acc_err        (acc_err)
  );

endmodule

//--- testbench/ahbl_slave_model.sv
// Behavioral AHB-Lite slave
`timescale 1ns/1ns

module ahbl_slave_model #(
  parameter int seed_init = 32'h388e_6c6f
) (
  input  logic        ahbl_gated_clk,
  input  logic        cpurst_b,
  input  logic [31:0] haddr,
  input  logic [1:0]  htrans,
  input  logic        hwrite,
  input  logic [31:0] hwdata,
  output logic [31:0] hrdata,
  output logic        hready,
  output logic        hresp
);
  import ahbl_pkg::*;

  logic [31:0] mem [logic [29:0]];
  integer      seed = seed_init;
  logic [31:0] rnd;
  logic        dp_active;
  logic        dp_write;
  logic        dp_err;
  logic [31:0] dp_addr;
  logic [1:0]  wait_left;

  // Unwritten words read back a pattern of their address
  function automatic logic [31:0] word_at(logic [31:0] addr);
    if (mem.exists(addr[31:2]))
      return mem[addr[31:2]];
    return addr ^ 32'h5a5a_0000;
  endfunction

  always @(posedge ahbl_gated_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      hready    <= 1'b1;
      hresp     <= 1'b0;
      hrdata    <= '0;
      dp_active <= 1'b0;
      wait_left <= '0;
    end
    else if (hready)
    begin
      // Data phase ends here, an ERROR response drops the write
      if (dp_active && dp_write && !hresp)
        mem[dp_addr[31:2]] = hwdata;
      rnd = $random(seed);
      if (htrans == htrans_nonseq)
      begin
        dp_active <= 1'b1;
        dp_addr   <= haddr;
        dp_write  <= hwrite;
        dp_err    <= haddr[31];
        wait_left <= rnd[1:0];
        hready    <= (rnd[1:0] == 2'd0) && !haddr[31];
        hresp     <= (rnd[1:0] == 2'd0) && haddr[31];
        if (!hwrite)
          hrdata <= word_at(haddr);
      end
      else
      begin
        dp_active <= 1'b0;
        hresp     <= 1'b0;
        // Occasional stall, as if another data phase held the bus
        hready    <= (rnd[4:2] != 3'd0);
      end
    end
    else if (!dp_active)
      hready <= 1'b1;
    else if (hresp)
      hready <= 1'b1;
    else if (wait_left > 2'd1)
      wait_left <= wait_left - 2'd1;
    else
    begin
      // Last wait state, then OKAY or first ERROR cycle
      hready <= !dp_err;
      hresp  <= dp_err;
      if (!dp_write)
        hrdata <= word_at(dp_addr);
    end
  end

endmodule

//--- testbench/tb_ahbl_master.sv
// AHB-Lite master testbench
`timescale 1ns/1ns

module tb_ahbl_master;
  import ahbl_pkg::*;

  localparam int seed_init = 32'h388e_6c6f;
  localparam int n_rand    = 30;
  localparam int n_xfers   = 10 + 2 * n_rand;

  logic               ahbl_gated_clk;
  logic               cpurst_b;
  logic               dbus_req, dbus_write, dbus_acc_deny;
  logic               dbus_grnt, dbus_trans_cmplt, dbus_acc_err;
  logic               ibus_req, ibus_acc_deny;
  logic               ibus_grnt, ibus_trans_cmplt, ibus_acc_err;
  logic [31:0]        dbus_addr, ibus_addr, haddr;
  logic [31:0]        dbus_wdata, dbus_rdata, ibus_rdata, hwdata, hrdata;
  logic [prot_w-1:0]  dbus_prot, ibus_prot, hprot;
  logic [size_w-1:0]  dbus_size, ibus_size;
  logic [hsize_w-1:0] hsize;
  logic [1:0]         htrans;
  logic [2:0]         hburst;
  logic               hwrite, hready, hresp;

  // Checker state
  integer             seed = seed_init;
  int                 value_errs = 0;
  int                 proto_errs = 0;
  int                 n_grants;
  int                 n_cmplts;
  int unsigned        cyc, pend_cyc;
  logic               in_flight, pend_port, pend_write, pend_deny, pend_err;
  logic [31:0]        pend_addr, pend_wdata, pend_exp;
  logic [prot_w-1:0]  pend_prot;
  logic [size_w-1:0]  pend_size;
  logic [31:0]        shadow [logic [29:0]];
  logic               any_grnt, any_cmplt, win_deny;
  logic [31:0]        win_addr, cmplt_rdata, rnd_a, rnd_d;
  logic [39:0]        ctrl_bus, ctrl_prev;

  ahbl_master_top #(
    .addr_width (32),
    .data_width (32)
  ) DUT (.*);

  ahbl_slave_model #(
    .seed_init (seed_init)
  ) u_slave (.*);

  assign any_grnt    = dbus_grnt | ibus_grnt;
  assign any_cmplt   = dbus_trans_cmplt | ibus_trans_cmplt;
  assign win_addr    = ibus_grnt ? ibus_addr : dbus_addr;
  assign win_deny    = ibus_grnt ? ibus_acc_deny : dbus_acc_deny;
  assign cmplt_rdata = ibus_trans_cmplt ? ibus_rdata : dbus_rdata;
  assign ctrl_bus    = {hwrite, hsize, hprot, haddr};

  initial
  begin
    ahbl_gated_clk = 1'b0;
    forever #10 ahbl_gated_clk = ~ahbl_gated_clk;
  end

  function automatic logic [31:0] expected_word(logic [31:0] addr);
    if (shadow.exists(addr[31:2]))
      return shadow[addr[31:2]];
    return addr ^ 32'h5a5a_0000;
  endfunction

  // Nine random bits into an address, low three select the error region
  function automatic logic [31:0] pick_addr(logic [8:0] r);
    return {r[2:0] == 3'b111, 23'd0, r[8:3], 2'b00};
  endfunction

  task automatic value_mismatch(string name, logic [63:0] exp, logic [63:0] act);
    value_errs++;
    $display("[ERROR] %s: expected %0h, actual %0h", name, exp, act);
  endtask

  task automatic protocol_fault(string what);
    proto_errs++;
    $display("Failure at %0t ns: %s", $time, what);
  endtask

  // ========================================
  // Outstanding request tracking
  // ========================================
  always @(posedge ahbl_gated_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      cyc       <= 0;
      in_flight <= 1'b0;
      n_grants  <= 0;
      n_cmplts  <= 0;
    end
    else
    begin
      cyc       <= cyc + 1;
      ctrl_prev <= ctrl_bus;
      if (any_grnt)
      begin
        in_flight  <= 1'b1;
        pend_port  <= ibus_grnt;
        pend_cyc   <= cyc;
        pend_addr  <= win_addr;
        pend_prot  <= ibus_grnt ? ibus_prot : dbus_prot;
        pend_size  <= ibus_grnt ? ibus_size : dbus_size;
        pend_write <= dbus_grnt & dbus_write;
        pend_wdata <= dbus_wdata;
        pend_deny  <= win_deny;
        pend_err   <= win_addr[31] & ~win_deny;
        pend_exp   <= expected_word(win_addr);
        n_grants   <= n_grants + 1;
      end
      else if (any_cmplt)
      begin
        in_flight <= 1'b0;
        n_cmplts  <= n_cmplts + 1;
        if (pend_write && !pend_deny && !pend_err)
          shadow[pend_addr[31:2]] = pend_wdata;
      end
    end
  end

  // ========================================
  // Checks
  // ========================================
  a_read_data: assert property (@(posedge ahbl_gated_clk) disable iff (!cpurst_b)
    any_cmplt && !pend_write && !pend_deny && !pend_err |-> cmplt_rdata == pend_exp)
    else value_mismatch("read data", $sampled(pend_exp), $sampled(cmplt_rdata));

  a_write_data: assert property (@(posedge ahbl_gated_clk) disable iff (!cpurst_b)
    any_cmplt && pend_write && !pend_deny && !pend_err |-> hwdata == pend_wdata)
    else value_mismatch("write data", $sampled(pend_wdata), $sampled(hwdata));

  a_dbus_first: assert property (@(posedge ahbl_gated_clk) disable iff (!cpurst_b)
    dbus_req && ibus_req |-> !ibus_grnt)
    else protocol_fault("ibus granted while dbus was requesting");

  a_one_in_flight: assert property (@(posedge ahbl_gated_clk) disable iff (!cpurst_b)
    any_grnt |-> !in_flight)
    else protocol_fault("grant while a transfer was outstanding");

  a_cmplt_port: assert property (@(posedge ahbl_gated_clk) disable iff (!cpurst_b)
    any_cmplt |-> in_flight && !(dbus_trans_cmplt && ibus_trans_cmplt) &&
                  (ibus_trans_cmplt == pend_port))
    else protocol_fault("completion without a matching grant on that port");

  a_deny_latency: assert property (@(posedge ahbl_gated_clk) disable iff (!cpurst_b)
    any_cmplt && pend_deny |-> cyc - pend_cyc == 2)
    else value_mismatch("denied latency", 2, $sampled(cyc - pend_cyc));

  a_no_stray_nonseq: assert property (@(posedge ahbl_gated_clk) disable iff (!cpurst_b)
    htrans == htrans_nonseq |-> in_flight && !pend_deny)
    else protocol_fault("NONSEQ without a permitted request in flight");

  a_nonseq_start: assert property (@(posedge ahbl_gated_clk) disable iff (!cpurst_b)
    any_grnt && !win_deny |=> htrans == htrans_nonseq)
    else protocol_fault("NONSEQ missing in the cycle after grant");

  // Address phase carries the granted request, HSIZE zero-extended
  a_addr_ctrl: assert property (@(posedge ahbl_gated_clk) disable iff (!cpurst_b)
    htrans == htrans_nonseq |->
      ctrl_bus == {pend_write, 1'b0, pend_size, pend_prot, pend_addr})
    else value_mismatch("address phase",
                        $sampled({pend_write, 1'b0, pend_size, pend_prot, pend_addr}),
                        $sampled(ctrl_bus));

  // HBURST is always SINGLE
  a_hburst: assert property (@(posedge ahbl_gated_clk) disable iff (!cpurst_b)
    hburst == 3'b000)
    else value_mismatch("hburst", 3'b000, $sampled(hburst));

  a_err_flag: assert property (@(posedge ahbl_gated_clk) disable iff (!cpurst_b)
    any_cmplt |-> (dbus_acc_err | ibus_acc_err) == pend_err)
    else value_mismatch("access error", $sampled(pend_err),
                        $sampled(dbus_acc_err | ibus_acc_err));

  a_err_routed: assert property (@(posedge ahbl_gated_clk) disable iff (!cpurst_b)
    dbus_acc_err || ibus_acc_err |->
      (dbus_acc_err == dbus_trans_cmplt) && (ibus_acc_err == ibus_trans_cmplt))
    else protocol_fault("acc_err raised apart from the issuing port's completion");

  a_wait_hold: assert property (@(posedge ahbl_gated_clk) disable iff (!cpurst_b)
    htrans == htrans_nonseq && !hready |=> htrans == htrans_nonseq && ctrl_bus == ctrl_prev)
    else value_mismatch("wait-state hold", $sampled(ctrl_prev), $sampled(ctrl_bus));

  // Requester side, fields held until grant
  task automatic issue(int port, logic [31:0] addr, logic wr, logic [31:0] data, logic deny);
    if (port == port_dbus)
    begin
      dbus_addr     = addr;
      dbus_write    = wr;
      dbus_wdata    = data;
      dbus_acc_deny = deny;
      dbus_req      = 1'b1;
    end
    else
    begin
      ibus_addr     = addr;
      ibus_acc_deny = deny;
      ibus_req      = 1'b1;
    end
    do
      @(posedge ahbl_gated_clk);
    while (port == port_dbus ? !dbus_grnt : !ibus_grnt);
    #2;
    if (port == port_dbus)
      dbus_req = 1'b0;
    else
      ibus_req = 1'b0;
    do
      @(posedge ahbl_gated_clk);
    while (port == port_dbus ? !dbus_trans_cmplt : !ibus_trans_cmplt);
    #2;
  endtask

  initial
  begin
    repeat (n_xfers * 12 + 50) @(posedge ahbl_gated_clk);
    $display("Watchdog expired before all transfers completed");
    $display(">>> FAIL");
    $finish;
  end

  // ========================================
  // Stimulus
  // ========================================
  initial
  begin
    cpurst_b      = 1'b0;
    dbus_req      = 1'b0;
    dbus_addr     = '0;
    dbus_prot     = 4'b0011;
    dbus_size     = 2'b10;
    dbus_write    = 1'b0;
    dbus_wdata    = '0;
    dbus_acc_deny = 1'b0;
    ibus_req      = 1'b0;
    ibus_addr     = '0;
    ibus_prot     = 4'b0010;
    ibus_size     = 2'b10;
    ibus_acc_deny = 1'b0;
    repeat (5) @(posedge ahbl_gated_clk);
    #2;
    cpurst_b = 1'b1;
    @(posedge ahbl_gated_clk);
    #2;
    issue(port_ibus, 32'h0000_0100, 1'b0, '0, 1'b0);
    issue(port_dbus, 32'h0000_0200, 1'b1, 32'hcafe_0001, 1'b0);
    issue(port_dbus, 32'h0000_0200, 1'b0, '0, 1'b0);
    // Both ports in the same cycle
    fork
      issue(port_dbus, 32'h0000_0300, 1'b1, 32'h1234_5678, 1'b0);
      issue(port_ibus, 32'h0000_0304, 1'b0, '0, 1'b0);
    join
    issue(port_ibus, 32'h0000_0300, 1'b0, '0, 1'b0);
    issue(port_ibus, 32'h0000_0400, 1'b0, '0, 1'b1);
    issue(port_dbus, 32'h8000_0010, 1'b1, 32'h0bad_0bad, 1'b1);
    issue(port_dbus, 32'h8000_0020, 1'b0, '0, 1'b0);
    issue(port_ibus, 32'h8000_0040, 1'b0, '0, 1'b0);
    for (int i = 0; i < n_rand; i++)
    begin
      rnd_a = $random(seed);
      rnd_d = $random(seed);
      fork
        if (rnd_a[0])
          issue(port_dbus, pick_addr(rnd_a[9:1]), rnd_a[10], rnd_d, rnd_a[13:11] == 3'd0);
        if (rnd_a[26] || !rnd_a[0])
          issue(port_ibus, pick_addr(rnd_a[22:14]), 1'b0, '0, rnd_a[25:23] == 3'd0);
      join
    end
    repeat (3) @(posedge ahbl_gated_clk);
    a_all_done: assert (!in_flight && n_grants == n_cmplts)
      else protocol_fault("grant count does not match completion count");
    $display("Errors: value %0d, protocol %0d", value_errs, proto_errs);
    if (value_errs + proto_errs == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

//--- all.f
hdl/ahbl_pkg.sv
hdl/ahbl_req_arb.sv
hdl/ahbl_req_buf.sv
hdl/ahbl_master_fsm.sv
hdl/ahbl_master_top.sv
testbench/ahbl_slave_model.sv
testbench/tb_ahbl_master.sv
